/* rtl/csr_pkg.sv */
package csr_pkg;

    localparam int CSR_NUM_W  = 14;
    localparam int DATA_W     = 32;
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;

    // register numbers
    localparam logic [CSR_NUM_W-1:0] CSR_CRMD   = 14'h000;
    localparam logic [CSR_NUM_W-1:0] CSR_PRMD   = 14'h001;
    localparam logic [CSR_NUM_W-1:0] CSR_ECFG   = 14'h004;
    localparam logic [CSR_NUM_W-1:0] CSR_ESTAT  = 14'h005;
    localparam logic [CSR_NUM_W-1:0] CSR_ERA    = 14'h006;
    localparam logic [CSR_NUM_W-1:0] CSR_BADV   = 14'h007;
    localparam logic [CSR_NUM_W-1:0] CSR_EENTRY = 14'h00c;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE0  = 14'h030;
    localparam logic [CSR_NUM_W-1:0] CSR_TID    = 14'h040;
    localparam logic [CSR_NUM_W-1:0] CSR_TCFG   = 14'h041;
    localparam logic [CSR_NUM_W-1:0] CSR_TVAL   = 14'h042;
    localparam logic [CSR_NUM_W-1:0] CSR_TICLR  = 14'h044;

    // exception codes that capture BADV
    localparam logic [ECODE_W-1:0]    ECODE_ADE     = 6'h08;
    localparam logic [ECODE_W-1:0]    ECODE_ALE     = 6'h09;
    localparam logic [ESUBCODE_W-1:0] ESUBCODE_ADEF = 9'h000;

    // writable ECFG.LIE bits, bit 10 reserved
    localparam logic [12:0] LIE_MASK = 13'h1bff;

    // select bit positions, SAVE slots follow SEL_SAVE0
    typedef enum int unsigned {
        SEL_CRMD,
        SEL_PRMD,
        SEL_ECFG,
        SEL_ESTAT,
        SEL_ERA,
        SEL_BADV,
        SEL_EENTRY,
        SEL_TID,
        SEL_TCFG,
        SEL_TVAL,
        SEL_TICLR,
        SEL_SAVE0
    } reg_sel_e;

    typedef union packed {
        logic [DATA_W-1:0] raw;
        struct packed {
            logic [29:0] initval;
            logic        periodic;
            logic        en;
        } f;
    } tcfg_word_u;

    // new bit where the mask is set, old bit elsewhere
    function automatic logic [DATA_W-1:0] mask_merge(
        input logic [DATA_W-1:0] old_value,
        input logic [DATA_W-1:0] wmask,
        input logic [DATA_W-1:0] wvalue
    );
        return (wmask & wvalue) | (~wmask & old_value);
    endfunction

endpackage

/* rtl/csr_write_if.sv */
`timescale 1ns/1ps

interface csr_write_if #(
    parameter int N_SAVE = 4
);
    import csr_pkg::*;

    logic                          valid;
    logic [SEL_SAVE0+N_SAVE-1:0]   sel;
    logic [DATA_W-1:0]             wmask;
    logic [DATA_W-1:0]             wvalue;

    modport source (
        output valid, sel, wmask, wvalue
    );

    modport sink (
        input valid, sel, wmask, wvalue
    );

endinterface

/* rtl/csr_write_decode.sv */
`timescale 1ns/1ps

module csr_write_decode #(
    parameter int N_SAVE = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           csr_we,
    input  logic [csr_pkg::CSR_NUM_W-1:0]  csr_num,
    input  logic [csr_pkg::DATA_W-1:0]     csr_wmask,
    input  logic [csr_pkg::DATA_W-1:0]     csr_wvalue,
    csr_write_if.source                    wr
);
    import csr_pkg::*;

    logic [SEL_SAVE0+N_SAVE-1:0] sel;

    always_comb begin
        sel = '0;
        case (csr_num)
            CSR_CRMD:   sel[SEL_CRMD]   = 1'b1;
            CSR_PRMD:   sel[SEL_PRMD]   = 1'b1;
            CSR_ECFG:   sel[SEL_ECFG]   = 1'b1;
            CSR_ESTAT:  sel[SEL_ESTAT]  = 1'b1;
            CSR_ERA:    sel[SEL_ERA]    = 1'b1;
            CSR_BADV:   sel[SEL_BADV]   = 1'b1;
            CSR_EENTRY: sel[SEL_EENTRY] = 1'b1;
            CSR_TID:    sel[SEL_TID]    = 1'b1;
            CSR_TCFG:   sel[SEL_TCFG]   = 1'b1;
            CSR_TVAL:   sel[SEL_TVAL]   = 1'b1;
            CSR_TICLR:  sel[SEL_TICLR]  = 1'b1;
            default: ;
        endcase
        // save slots sit at consecutive numbers
        for (int i = 0; i < N_SAVE; i++) begin
            if (csr_num == CSR_SAVE0 + CSR_NUM_W'(i)) begin
                sel[SEL_SAVE0+i] = 1'b1;
            end
        end
    end

    assign wr.valid  = csr_we;
    assign wr.sel    = sel;
    assign wr.wmask  = csr_wmask;
    assign wr.wvalue = csr_wvalue;

    // at most one bank register may take a write
    a_sel_onehot: assert property (
        @(posedge clk) disable iff (reset) $onehot0(wr.sel)
    );

endmodule

/* rtl/exc_csr_bank.sv */
`timescale 1ns/1ps

module exc_csr_bank #(
    parameter int N_SAVE = 4
) (
    input  logic                                  clk,
    input  logic                                  reset,
    csr_write_if.sink                             wr,
    input  logic                                  wb_ex,
    input  logic [csr_pkg::ECODE_W-1:0]           wb_ecode,
    input  logic [csr_pkg::ESUBCODE_W-1:0]        wb_esubcode,
    input  logic [csr_pkg::DATA_W-1:0]            wb_vaddr,
    input  logic [csr_pkg::DATA_W-1:0]            wb_pc,
    input  logic                                  ertn_flush,
    input  logic                                  timer_int,
    output logic [csr_pkg::DATA_W-1:0]            crmd,
    output logic [csr_pkg::DATA_W-1:0]            prmd,
    output logic [csr_pkg::DATA_W-1:0]            ecfg,
    output logic [csr_pkg::DATA_W-1:0]            estat,
    output logic [csr_pkg::DATA_W-1:0]            era,
    output logic [csr_pkg::DATA_W-1:0]            eentry,
    output logic [csr_pkg::DATA_W-1:0]            badv,
    output logic [N_SAVE-1:0][csr_pkg::DATA_W-1:0] save,
    output logic [csr_pkg::DATA_W-1:0]            ex_entry,
    output logic [csr_pkg::DATA_W-1:0]            ertn_entry,
    output logic                                  has_int
);
    import csr_pkg::*;

    logic [1:0]            crmd_plv;
    logic                  crmd_ie;
    logic [1:0]            prmd_pplv;
    logic                  prmd_pie;
    logic [12:0]           ecfg_lie;
    logic [1:0]            estat_is_sw;
    logic [ECODE_W-1:0]    estat_ecode;
    logic [ESUBCODE_W-1:0] estat_esubcode;
    logic [DATA_W-1:0]     era_pc;
    logic [25:0]           eentry_va;
    logic [DATA_W-1:0]     badv_vaddr;
    logic                  addr_err;
    logic [DATA_W-1:0]     crmd_merged;
    logic [DATA_W-1:0]     prmd_merged;
    logic [DATA_W-1:0]     ecfg_merged;
    logic [DATA_W-1:0]     estat_merged;
    logic [DATA_W-1:0]     eentry_merged;

    assign crmd   = {29'b0, crmd_ie, crmd_plv};
    assign prmd   = {29'b0, prmd_pie, prmd_pplv};
    assign ecfg   = {19'b0, ecfg_lie};
    // bit 11 comes straight from the timer, hw and ipi lines are absent
    assign estat  = {1'b0, estat_esubcode, estat_ecode, 3'b0, 1'b0, timer_int, 9'b0, estat_is_sw};
    assign era    = era_pc;
    assign eentry = {eentry_va, 6'b0};
    assign badv   = badv_vaddr;

    assign crmd_merged   = mask_merge(crmd, wr.wmask, wr.wvalue);
    assign prmd_merged   = mask_merge(prmd, wr.wmask, wr.wvalue);
    assign ecfg_merged   = mask_merge(ecfg, wr.wmask, wr.wvalue);
    assign estat_merged  = mask_merge(estat, wr.wmask, wr.wvalue);
    assign eentry_merged = mask_merge(eentry, wr.wmask, wr.wvalue);

    assign addr_err = (wb_ecode == ECODE_ADE) || (wb_ecode == ECODE_ALE);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr.valid && wr.sel[SEL_CRMD]) begin
            {crmd_ie, crmd_plv} <= crmd_merged[2:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= 2'b0;
            prmd_pie  <= 1'b0;
        end else if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (wr.valid && wr.sel[SEL_PRMD]) begin
            {prmd_pie, prmd_pplv} <= prmd_merged[2:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= 13'b0;
        end else if (wr.valid && wr.sel[SEL_ECFG]) begin
            ecfg_lie <= ecfg_merged[12:0] & LIE_MASK;
        end
    end

    // only the two software interrupt bits are writable
    always_ff @(posedge clk) begin
        if (reset) begin
            estat_is_sw    <= 2'b0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else begin
            if (wr.valid && wr.sel[SEL_ESTAT]) begin
                estat_is_sw <= estat_merged[1:0];
            end
            if (wb_ex) begin
                estat_ecode    <= wb_ecode;
                estat_esubcode <= wb_esubcode;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            era_pc <= wb_pc;
        end else if (wr.valid && wr.sel[SEL_ERA]) begin
            era_pc <= mask_merge(era_pc, wr.wmask, wr.wvalue);
        end
        if (wb_ex && addr_err) begin
            // fetch faults report the pc itself
            badv_vaddr <= (wb_ecode == ECODE_ADE && wb_esubcode == ESUBCODE_ADEF) ?
                          wb_pc : wb_vaddr;
        end else if (wr.valid && wr.sel[SEL_BADV]) begin
            badv_vaddr <= mask_merge(badv_vaddr, wr.wmask, wr.wvalue);
        end
        if (wr.valid && wr.sel[SEL_EENTRY]) begin
            eentry_va <= eentry_merged[31:6];
        end
        for (int i = 0; i < N_SAVE; i++) begin
            if (wr.valid && wr.sel[SEL_SAVE0+i]) begin
                save[i] <= mask_merge(save[i], wr.wmask, wr.wvalue);
            end
        end
    end

    assign ex_entry   = eentry;
    assign ertn_entry = era;
    assign has_int    = (|(estat[11:0] & ecfg[11:0])) & crmd_ie;

    // the writeback stage never retires both in one cycle
    a_ex_ertn_excl: assert property (
        @(posedge clk) disable iff (reset) !(wb_ex && ertn_flush)
    );

endmodule

/* rtl/csr_timer.sv */
`timescale 1ns/1ps

module csr_timer (
    input  logic                       clk,
    input  logic                       reset,
    csr_write_if.sink                  wr,
    output logic [csr_pkg::DATA_W-1:0] tid,
    output logic [csr_pkg::DATA_W-1:0] tcfg,
    output logic [csr_pkg::DATA_W-1:0] tval,
    output logic                       timer_int
);
    import csr_pkg::*;

    logic [DATA_W-1:0] tid_q;
    tcfg_word_u        tcfg_q;
    tcfg_word_u        tcfg_next;
    logic [DATA_W-1:0] cnt;
    logic              wr_tcfg;
    logic              ticlr;

    assign wr_tcfg = wr.valid && wr.sel[SEL_TCFG];
    assign ticlr   = wr.valid && wr.sel[SEL_TICLR] && wr.wmask[0] && wr.wvalue[0];

    always_comb begin
        tcfg_next.raw = mask_merge(tcfg_q.raw, wr.wmask, wr.wvalue);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tid_q      <= '0;
            tcfg_q.raw <= '0;
        end else begin
            if (wr.valid && wr.sel[SEL_TID]) begin
                tid_q <= mask_merge(tid_q, wr.wmask, wr.wvalue);
            end
            if (wr_tcfg) begin
                tcfg_q <= tcfg_next;
            end
        end
    end

    // all ones means stopped
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '1;
        end else if (wr_tcfg && tcfg_next.f.en) begin
            cnt <= {tcfg_next.f.initval, 2'b00};
        end else if (tcfg_q.f.en && cnt != '1) begin
            if (cnt == '0 && tcfg_q.f.periodic) begin
                cnt <= {tcfg_q.f.initval, 2'b00};
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // expiry wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (cnt == '0) begin
            timer_int <= 1'b1;
        end else if (ticlr) begin
            timer_int <= 1'b0;
        end
    end

    assign tid  = tid_q;
    assign tcfg = tcfg_q.raw;
    assign tval = cnt;

    a_cnt_hold: assert property (
        @(posedge clk) disable iff (reset)
        (!tcfg_q.f.en && !wr_tcfg) |=> $stable(cnt)
    );

endmodule

/* rtl/csr_read_select.sv */
`timescale 1ns/1ps

module csr_read_select #(
    parameter int N_SAVE = 4
) (
    input  logic [csr_pkg::CSR_NUM_W-1:0]           csr_num,
    input  logic [csr_pkg::DATA_W-1:0]              crmd,
    input  logic [csr_pkg::DATA_W-1:0]              prmd,
    input  logic [csr_pkg::DATA_W-1:0]              ecfg,
    input  logic [csr_pkg::DATA_W-1:0]              estat,
    input  logic [csr_pkg::DATA_W-1:0]              era,
    input  logic [csr_pkg::DATA_W-1:0]              eentry,
    input  logic [csr_pkg::DATA_W-1:0]              badv,
    input  logic [N_SAVE-1:0][csr_pkg::DATA_W-1:0]  save,
    input  logic [csr_pkg::DATA_W-1:0]              tid,
    input  logic [csr_pkg::DATA_W-1:0]              tcfg,
    input  logic [csr_pkg::DATA_W-1:0]              tval,
    output logic [csr_pkg::DATA_W-1:0]              csr_rvalue
);
    import csr_pkg::*;

    always_comb begin
        csr_rvalue = '0;
        case (csr_num)
            CSR_CRMD:   csr_rvalue = crmd;
            CSR_PRMD:   csr_rvalue = prmd;
            CSR_ECFG:   csr_rvalue = ecfg;
            CSR_ESTAT:  csr_rvalue = estat;
            CSR_ERA:    csr_rvalue = era;
            CSR_BADV:   csr_rvalue = badv;
            CSR_EENTRY: csr_rvalue = eentry;
            CSR_TID:    csr_rvalue = tid;
            CSR_TCFG:   csr_rvalue = tcfg;
            CSR_TVAL:   csr_rvalue = tval;
            // clear-only register
            CSR_TICLR:  csr_rvalue = '0;
            default: ;
        endcase
        for (int i = 0; i < N_SAVE; i++) begin
            if (csr_num == CSR_SAVE0 + CSR_NUM_W'(i)) begin
                csr_rvalue = save[i];
            end
        end
    end

endmodule

/* rtl/csr_file.sv */
`timescale 1ns/1ps

module csr_file #(
    parameter int N_SAVE = 4
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            csr_we,
    input  logic [csr_pkg::CSR_NUM_W-1:0]   csr_num,
    input  logic [csr_pkg::DATA_W-1:0]      csr_wmask,
    input  logic [csr_pkg::DATA_W-1:0]      csr_wvalue,
    output logic [csr_pkg::DATA_W-1:0]      csr_rvalue,
    input  logic                            wb_ex,
    input  logic [csr_pkg::ECODE_W-1:0]     wb_ecode,
    input  logic [csr_pkg::ESUBCODE_W-1:0]  wb_esubcode,
    input  logic [csr_pkg::DATA_W-1:0]      wb_vaddr,
    input  logic [csr_pkg::DATA_W-1:0]      wb_pc,
    input  logic                            ertn_flush,
    output logic [csr_pkg::DATA_W-1:0]      ex_entry,
    output logic [csr_pkg::DATA_W-1:0]      ertn_entry,
    output logic                            has_int
);
    import csr_pkg::*;

    logic [DATA_W-1:0]             crmd;
    logic [DATA_W-1:0]             prmd;
    logic [DATA_W-1:0]             ecfg;
    logic [DATA_W-1:0]             estat;
    logic [DATA_W-1:0]             era;
    logic [DATA_W-1:0]             eentry;
    logic [DATA_W-1:0]             badv;
    logic [N_SAVE-1:0][DATA_W-1:0] save;
    logic [DATA_W-1:0]             tid;
    logic [DATA_W-1:0]             tcfg;
    logic [DATA_W-1:0]             tval;
    logic                          timer_int;

    csr_write_if #(.N_SAVE(N_SAVE)) wr_bus ();

    csr_write_decode #(.N_SAVE(N_SAVE)) u_write_decode (
        .clk        (clk),
        .reset      (reset),
        .csr_we     (csr_we),
        .csr_num    (csr_num),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .wr         (wr_bus.source)
    );

    exc_csr_bank #(.N_SAVE(N_SAVE)) u_exc_bank (
        .clk         (clk),
        .reset       (reset),
        .wr          (wr_bus.sink),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_vaddr    (wb_vaddr),
        .wb_pc       (wb_pc),
        .ertn_flush  (ertn_flush),
        .timer_int   (timer_int),
        .crmd        (crmd),
        .prmd        (prmd),
        .ecfg        (ecfg),
        .estat       (estat),
        .era         (era),
        .eentry      (eentry),
        .badv        (badv),
        .save        (save),
        .ex_entry    (ex_entry),
        .ertn_entry  (ertn_entry),
        .has_int     (has_int)
    );

    csr_timer u_timer (
        .clk       (clk),
        .reset     (reset),
        .wr        (wr_bus.sink),
        .tid       (tid),
        .tcfg      (tcfg),
        .tval      (tval),
        .timer_int (timer_int)
    );

    csr_read_select #(.N_SAVE(N_SAVE)) u_read_select (
        .csr_num    (csr_num),
        .crmd       (crmd),
        .prmd       (prmd),
        .ecfg       (ecfg),
        .estat      (estat),
        .era        (era),
        .eentry     (eentry),
        .badv       (badv),
        .save       (save),
        .tid        (tid),
        .tcfg       (tcfg),
        .tval       (tval),
        .csr_rvalue (csr_rvalue)
    );

endmodule

/* testbench/csr_model.svh */
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// reference state, one update per rising edge
logic [1:0]  m_plv;
logic        m_ie;
logic [1:0]  m_pplv;
logic        m_pie;
logic [12:0] m_lie;
logic [1:0]  m_swi;
logic [5:0]  m_ecode;
logic [8:0]  m_esub;
logic [31:0] m_era;
logic [31:0] m_eentry;
logic [31:0] m_badv;
logic [31:0] m_save [4];
logic [31:0] m_tid;
logic [31:0] m_tcfg;
logic [31:0] m_cnt;
logic        m_ti;

localparam logic [5:0] M_ADE = 6'h08;
localparam logic [5:0] M_ALE = 6'h09;

function automatic logic [31:0] merge_bits(input logic [31:0] old_v, input logic [31:0] mask,
                                           input logic [31:0] val);
    return (old_v & ~mask) | (val & mask);
endfunction

function automatic logic [31:0] expected_estat();
    return {1'b0, m_esub, m_ecode, 4'b0, m_ti, 9'b0, m_swi};
endfunction

function automatic logic expected_has_int();
    return m_ie & (|(expected_estat() & {20'b0, m_lie[11:0]}));
endfunction

function automatic logic [31:0] expected_read(input logic [13:0] num);
    case (num)
        CSR_CRMD:   return {29'b0, m_ie, m_plv};
        CSR_PRMD:   return {29'b0, m_pie, m_pplv};
        CSR_ECFG:   return {19'b0, m_lie};
        CSR_ESTAT:  return expected_estat();
        CSR_ERA:    return m_era;
        CSR_BADV:   return m_badv;
        CSR_EENTRY: return m_eentry;
        CSR_TID:    return m_tid;
        CSR_TCFG:   return m_tcfg;
        CSR_TVAL:   return m_cnt;
        default: begin
            if (num >= CSR_SAVE0 && num <= CSR_SAVE0 + 14'd3) begin
                return m_save[num[1:0]];
            end
            return 32'h0;
        end
    endcase
endfunction

task automatic reset_model();
    m_plv = 2'b0;
    m_ie = 1'b0;
    m_pplv = 2'b0;
    m_pie = 1'b0;
    m_lie = 13'b0;
    m_swi = 2'b0;
    m_ecode = 6'b0;
    m_esub = 9'b0;
    m_era = 32'h0;
    m_eentry = 32'h0;
    m_badv = 32'h0;
    for (int i = 0; i < 4; i++) begin
        m_save[i] = 32'h0;
    end
    m_tid = 32'h0;
    m_tcfg = 32'h0;
    m_cnt = 32'hffff_ffff;
    m_ti = 1'b0;
endtask

// uses the inputs the DUT sampled at this edge
task automatic step_model();
    logic [31:0] merged;
    logic [1:0]  old_plv;
    logic        old_ie;
    logic [1:0]  old_pplv;
    logic        old_pie;
    logic [31:0] old_cnt;
    logic [31:0] old_tcfg;
    old_plv = m_plv;
    old_ie = m_ie;
    old_pplv = m_pplv;
    old_pie = m_pie;
    old_cnt = m_cnt;
    old_tcfg = m_tcfg;
    merged = merge_bits(expected_read(csr_num), csr_wmask, csr_wvalue);
    if (csr_we) begin
        case (csr_num)
            CSR_CRMD:   {m_ie, m_plv} = merged[2:0];
            CSR_PRMD:   {m_pie, m_pplv} = merged[2:0];
            CSR_ECFG:   m_lie = merged[12:0] & 13'h1bff;
            CSR_ESTAT:  m_swi = merged[1:0];
            CSR_ERA:    m_era = merged;
            CSR_BADV:   m_badv = merged;
            CSR_EENTRY: m_eentry = merged & 32'hffff_ffc0;
            CSR_TID:    m_tid = merged;
            CSR_TCFG:   m_tcfg = merged;
            default: begin
                if (csr_num >= CSR_SAVE0 && csr_num <= CSR_SAVE0 + 14'd3) begin
                    m_save[csr_num[1:0]] = merged;
                end
            end
        endcase
    end
    // events override a software write
    if (ertn_flush) begin
        m_plv = old_pplv;
        m_ie = old_pie;
    end
    if (wb_ex) begin
        m_plv = 2'b0;
        m_ie = 1'b0;
        m_pplv = old_plv;
        m_pie = old_ie;
        m_ecode = wb_ecode;
        m_esub = wb_esubcode;
        m_era = wb_pc;
        if (wb_ecode == M_ADE) begin
            m_badv = (wb_esubcode == 9'h0) ? wb_pc : wb_vaddr;
        end else if (wb_ecode == M_ALE) begin
            m_badv = wb_vaddr;
        end
    end
    if (csr_we && csr_num == CSR_TCFG && m_tcfg[0]) begin
        m_cnt = {m_tcfg[31:2], 2'b00};
    end else if (old_tcfg[0] && old_cnt != 32'hffff_ffff) begin
        if (old_cnt == 32'h0 && old_tcfg[1]) begin
            m_cnt = {old_tcfg[31:2], 2'b00};
        end else begin
            m_cnt = old_cnt - 32'd1;
        end
    end
    if (old_cnt == 32'h0) begin
        m_ti = 1'b1;
    end else if (csr_we && csr_num == CSR_TICLR && csr_wmask[0] && csr_wvalue[0]) begin
        m_ti = 1'b0;
    end
endtask

`endif

/* testbench/tb_csr_file.sv */
`timescale 1ns/1ps

module tb_csr_file;
    import csr_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int N_OPS        = 4000;
    localparam int MARGIN       = 50;

    logic        clk;
    logic        reset;
    logic        csr_we;
    logic [13:0] csr_num;
    logic [31:0] csr_wmask;
    logic [31:0] csr_wvalue;
    logic [31:0] csr_rvalue;
    logic        wb_ex;
    logic [5:0]  wb_ecode;
    logic [8:0]  wb_esubcode;
    logic [31:0] wb_vaddr;
    logic [31:0] wb_pc;
    logic        ertn_flush;
    logic [31:0] ex_entry;
    logic [31:0] ertn_entry;
    logic        has_int;

    int errors;
    int checks;
    bit checking;
    // timer registers listed twice so they come up more often
    logic [13:0] reg_list [18];

    `include "csr_model.svh"

    csr_file #(.N_SAVE(4)) DUT (
        .clk         (clk),
        .reset       (reset),
        .csr_we      (csr_we),
        .csr_num     (csr_num),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .csr_rvalue  (csr_rvalue),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_vaddr    (wb_vaddr),
        .wb_pc       (wb_pc),
        .ertn_flush  (ertn_flush),
        .ex_entry    (ex_entry),
        .ertn_entry  (ertn_entry),
        .has_int     (has_int)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("error %s got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic check_outputs();
        check("csr_rvalue", csr_rvalue, expected_read(csr_num));
        check("ex_entry", ex_entry, m_eentry);
        check("ertn_entry", ertn_entry, m_era);
        check("has_int", {31'b0, has_int}, {31'b0, expected_has_int()});
    endtask

    task automatic advance_edge();
        @(posedge clk);
        step_model();
        #1;
    endtask

    // inputs were driven 1 ns after the edge
    task automatic run_cycle();
        #2;
        if (checking) begin
            check_outputs();
        end
        advance_edge();
    endtask

    task automatic idle_inputs();
        csr_we = 1'b0;
        csr_wmask = 32'h0;
        csr_wvalue = 32'h0;
        wb_ex = 1'b0;
        wb_ecode = 6'h0;
        wb_esubcode = 9'h0;
        wb_vaddr = 32'h0;
        wb_pc = 32'h0;
        ertn_flush = 1'b0;
    endtask

    function automatic logic [13:0] pick_num();
        if ($urandom % 8 == 0) begin
            return 14'($urandom);
        end
        return reg_list[$urandom % 18];
    endfunction

    task automatic drive_write();
        csr_we = 1'b1;
        csr_wmask = ($urandom % 2 == 0) ? 32'hffff_ffff : $urandom;
        // small initval keeps expiry within reach
        csr_wvalue = (csr_num == CSR_TCFG) ? ($urandom % 64) : $urandom;
    endtask

    task automatic drive_exception();
        int unsigned pick;
        pick = $urandom % 3;
        wb_ex = 1'b1;
        wb_pc = $urandom;
        wb_vaddr = $urandom;
        wb_ecode = (pick == 0) ? 6'h08 : (pick == 1) ? 6'h09 : 6'($urandom);
        wb_esubcode = ($urandom % 2 == 0) ? 9'h0 : 9'($urandom);
    endtask

    task automatic draw_op();
        int unsigned kind;
        kind = $urandom % 16;
        idle_inputs();
        csr_num = pick_num();
        if (kind < 9) begin
            drive_write();
        end else if (kind < 11) begin
            drive_exception();
            if ($urandom % 3 == 0) drive_write();
        end else if (kind == 11) begin
            ertn_flush = 1'b1;
            if ($urandom % 3 == 0) drive_write();
        end
    endtask

    task automatic check_reset_values();
        logic [13:0] nums [6];
        logic [31:0] values [6];
        nums = '{CSR_CRMD, CSR_ECFG, CSR_ESTAT, CSR_TID, CSR_TCFG, CSR_TVAL};
        values = '{32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'hffff_ffff};
        check("has_int", {31'b0, has_int}, 32'h0);
        for (int i = 0; i < 6; i++) begin
            csr_num = nums[i];
            #0.5;
            check("csr_rvalue", csr_rvalue, values[i]);
        end
    endtask

    // registers without a reset get a known value first
    task automatic init_scratch();
        logic [13:0] nums [7];
        nums = '{CSR_ERA, CSR_BADV, CSR_EENTRY, CSR_SAVE0, CSR_SAVE0 + 14'd1,
                 CSR_SAVE0 + 14'd2, CSR_SAVE0 + 14'd3};
        for (int i = 0; i < 7; i++) begin
            idle_inputs();
            csr_we = 1'b1;
            csr_num = nums[i];
            csr_wmask = 32'hffff_ffff;
            csr_wvalue = $urandom;
            run_cycle();
        end
        idle_inputs();
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        csr_num = 14'h0;
        idle_inputs();
        errors = 0;
        checks = 0;
        checking = 1'b0;
        void'($urandom(13));
        reg_list = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA, CSR_BADV, CSR_EENTRY,
                     CSR_SAVE0, CSR_SAVE0 + 14'd1, CSR_SAVE0 + 14'd2, CSR_SAVE0 + 14'd3,
                     CSR_TID, CSR_TCFG, CSR_TVAL, CSR_TICLR, CSR_TCFG, CSR_TICLR, CSR_TVAL};
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        check_reset_values();
        advance_edge();
        init_scratch();
        checking = 1'b1;
        repeat (N_OPS) begin
            draw_op();
            run_cycle();
        end
        $display("errors %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + 8 + N_OPS + MARGIN));
        $display("timeout: the run did not complete in the expected time");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* csr_file.f */
+incdir+testbench
rtl/csr_pkg.sv
rtl/csr_write_if.sv
rtl/csr_write_decode.sv
rtl/exc_csr_bank.sv
rtl/csr_timer.sv
rtl/csr_read_select.sv
rtl/csr_file.sv
testbench/tb_csr_file.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_csr_file
BUILD_DIR ?= build
LOG       ?= sim.log
FILELIST  ?= csr_file.f
PASS_MSG  ?= STATUS: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard testbench/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) --binary --timing --assert -Wno-fatal -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	$(BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
